/* rtl/mem_defs.svh */
// Memory stage parameters
// data and line widths, cache geometry and address region decode

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define MEM_XLEN 64

// cache line and memory port width
`define MEM_LINE_W 128

// 16 lines
`define MEM_INDEX_W 4

// address bits 31:28 selecting the timer
`define MEM_CLINT_NIBBLE 4'h2
`define MEM_MTIME_SEL_BIT 15

`endif

/* rtl/mem_pkg.sv */
// Memory stage types
// load/store operation encoding and data cache controller states

package mem_pkg;

    // bits 1:0 give width, bit 2 selects zero-extend
    typedef enum logic [2:0] {
        OP_W  = 3'd0,
        OP_B  = 3'd1,
        OP_H  = 3'd2,
        OP_D  = 3'd3,
        OP_WU = 3'd4,
        OP_BU = 3'd5,
        OP_HU = 3'd6
    } mem_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_EVICT,
        S_REFILL,
        S_FLUSH,
        S_DONE
    } cache_state_e;

endpackage

/* rtl/store_align.sv */
// Store alignment
// shifts store data to its byte offset and builds the byte write mask

`timescale 1ns/1ps
`include "mem_defs.svh"

module store_align (
    input  mem_pkg::mem_op_e      op_i,
    input  logic [2:0]            offset_i,
    input  logic [`MEM_XLEN-1:0]  wdata_i,
    output logic [`MEM_XLEN-1:0]  data_o,
    output logic [7:0]            wmask_o
);

    logic [7:0]           base_mask;
    logic [`MEM_XLEN-1:0] shifted;

    // mask for an access at offset zero
    always_comb begin
        case (op_i[1:0])
            2'd0:    base_mask = 8'h0f;
            2'd1:    base_mask = 8'h01;
            2'd2:    base_mask = 8'h03;
            default: base_mask = 8'hff;
        endcase
    end

    assign wmask_o = base_mask << offset_i;
    assign shifted = wdata_i << {offset_i, 3'b000};

    // bytes outside the mask stay zero
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            data_o[b*8 +: 8] = wmask_o[b] ? shifted[b*8 +: 8] : 8'h00;
        end
    end

endmodule

/* rtl/load_extract.sv */
// Load extraction
// picks the addressed bytes from a 64-bit word and sign- or zero-extends them

`timescale 1ns/1ps
`include "mem_defs.svh"

module load_extract (
    input  mem_pkg::mem_op_e      op_i,
    input  logic [2:0]            offset_i,
    input  logic [`MEM_XLEN-1:0]  word_i,
    output logic [`MEM_XLEN-1:0]  rdata_o
);

    import mem_pkg::*;

    logic [`MEM_XLEN-1:0] shifted;

    // addressed byte moves down to bit 0
    assign shifted = word_i >> {offset_i, 3'b000};

    always_comb begin
        case (op_i)
            OP_B:    rdata_o = {{(`MEM_XLEN-8){shifted[7]}}, shifted[7:0]};
            OP_H:    rdata_o = {{(`MEM_XLEN-16){shifted[15]}}, shifted[15:0]};
            OP_W:    rdata_o = {{(`MEM_XLEN-32){shifted[31]}}, shifted[31:0]};
            OP_BU:   rdata_o = {{(`MEM_XLEN-8){1'b0}}, shifted[7:0]};
            OP_HU:   rdata_o = {{(`MEM_XLEN-16){1'b0}}, shifted[15:0]};
            OP_WU:   rdata_o = {{(`MEM_XLEN-32){1'b0}}, shifted[31:0]};
            // full doubleword, always aligned
            default: rdata_o = word_i;
        endcase
    end

endmodule

/* rtl/clint_timer.sv */
// CLINT-style timer
// free-running mtime, writable mtimecmp, registered timer interrupt

`timescale 1ns/1ps
`include "mem_defs.svh"

module clint_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we_i,
    input  logic                  sel_mtime_i,
    input  logic [`MEM_XLEN-1:0]  wdata_i,
    output logic [`MEM_XLEN-1:0]  rdata_o,
    output logic                  timer_irq_o
);

    logic [`MEM_XLEN-1:0] mtime_q;
    logic [`MEM_XLEN-1:0] mtimecmp_q;

    // mtimecmp resets to max so no interrupt fires until it is written
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            timer_irq_o <= 1'b0;
        end else begin
            mtime_q     <= mtime_q + 1'b1;
            timer_irq_o <= (mtime_q >= mtimecmp_q);
            if (we_i && !sel_mtime_i) begin
                mtimecmp_q <= wdata_i;
            end
        end
    end

    assign rdata_o = sel_mtime_i ? mtime_q : mtimecmp_q;

endmodule

/* rtl/dcache.sv */
// Data cache
// direct-mapped write-back cache, 16 lines of 128 bits, with eviction,
// refill over a four-phase req/ack port and a fence flush of all lines

`timescale 1ns/1ps
`include "mem_defs.svh"

module dcache (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cpu_req_valid_i,
    input  logic [`MEM_XLEN-1:0]    cpu_addr_i,
    input  logic                    cpu_we_i,
    input  logic [`MEM_XLEN-1:0]    cpu_wdata_i,
    input  logic [7:0]              cpu_wmask_i,
    output logic [`MEM_XLEN-1:0]    cpu_rdata_o,
    output logic                    cpu_ready_o,
    input  logic                    fence_i,
    output logic                    flushing_o,
    output logic                    mem_req_o,
    input  logic                    mem_ack_i,
    output logic [`MEM_XLEN-1:0]    mem_addr_o,
    output logic                    mem_we_o,
    output logic [`MEM_LINE_W-1:0]  mem_wdata_o,
    input  logic [`MEM_LINE_W-1:0]  mem_rdata_i
);

    import mem_pkg::*;

    localparam int LINES = 1 << `MEM_INDEX_W;
    localparam int OFF_W = $clog2(`MEM_LINE_W / 8);
    localparam int TAG_W = `MEM_XLEN - `MEM_INDEX_W - OFF_W;

    logic [`MEM_LINE_W-1:0]   data_mem [LINES];
    logic [TAG_W-1:0]         tag_mem  [LINES];
    logic [LINES-1:0]         valid_q;
    logic [LINES-1:0]         dirty_q;

    cache_state_e             state_q;
    logic                     mem_req_q;
    logic                     xfer_done_q;
    logic [`MEM_INDEX_W-1:0]  flush_idx_q;

    logic [`MEM_XLEN-1:0]     req_addr_q;
    logic                     req_we_q;
    logic [`MEM_XLEN-1:0]     req_wdata_q;
    logic [7:0]               req_wmask_q;

    logic [`MEM_INDEX_W-1:0]  req_idx;
    logic [TAG_W-1:0]         req_tag;
    logic                     hit;
    logic                     need_wb;
    logic                     xfer_active;
    logic                     xfer_end;
    logic [`MEM_LINE_W-1:0]   line_rd;
    logic [`MEM_XLEN-1:0]     cur_word;
    logic [`MEM_XLEN-1:0]     new_word;
    logic [`MEM_LINE_W-1:0]   merged_line;

    assign req_idx = req_addr_q[OFF_W +: `MEM_INDEX_W];
    assign req_tag = req_addr_q[`MEM_XLEN-1 -: TAG_W];
    assign line_rd = data_mem[req_idx];
    assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign need_wb = valid_q[flush_idx_q] && dirty_q[flush_idx_q];

    // memory transfer in progress for the current state
    assign xfer_active = (state_q == S_EVICT) || (state_q == S_REFILL) ||
                         ((state_q == S_FLUSH) && need_wb);
    // ack seen and dropped again
    assign xfer_end    = xfer_done_q && !mem_ack_i;

    assign cpu_ready_o = ((state_q == S_LOOKUP) && hit) || (state_q == S_DONE);
    assign flushing_o  = (state_q == S_FLUSH);
    assign mem_req_o   = mem_req_q;

    // word select is the bit above the byte offset
    always_comb begin
        cur_word = req_addr_q[OFF_W-1] ? line_rd[`MEM_LINE_W-1 -: `MEM_XLEN]
                                       : line_rd[`MEM_XLEN-1:0];
        new_word = cur_word;
        for (int b = 0; b < 8; b++) begin
            if (req_wmask_q[b]) begin
                new_word[b*8 +: 8] = req_wdata_q[b*8 +: 8];
            end
        end
        merged_line = line_rd;
        if (req_addr_q[OFF_W-1]) begin
            merged_line[`MEM_LINE_W-1 -: `MEM_XLEN] = new_word;
        end else begin
            merged_line[`MEM_XLEN-1:0] = new_word;
        end
    end

    assign cpu_rdata_o = cur_word;

    // port fields stay fixed for the whole handshake
    always_comb begin
        case (state_q)
            S_EVICT: begin
                mem_addr_o  = {tag_mem[req_idx], req_idx, {OFF_W{1'b0}}};
                mem_we_o    = 1'b1;
                mem_wdata_o = line_rd;
            end
            S_FLUSH: begin
                mem_addr_o  = {tag_mem[flush_idx_q], flush_idx_q, {OFF_W{1'b0}}};
                mem_we_o    = 1'b1;
                mem_wdata_o = data_mem[flush_idx_q];
            end
            default: begin
                mem_addr_o  = {req_tag, req_idx, {OFF_W{1'b0}}};
                mem_we_o    = 1'b0;
                mem_wdata_o = line_rd;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && cpu_req_valid_i) begin
            req_addr_q  <= cpu_addr_i;
            req_we_q    <= cpu_we_i;
            req_wdata_q <= cpu_wdata_i;
            req_wmask_q <= cpu_wmask_i;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == S_REFILL) && mem_req_q && mem_ack_i) begin
            data_mem[req_idx] <= mem_rdata_i;
            tag_mem[req_idx]  <= req_tag;
        end else if (cpu_ready_o && req_we_q) begin
            data_mem[req_idx] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_IDLE;
            mem_req_q   <= 1'b0;
            xfer_done_q <= 1'b0;
            flush_idx_q <= '0;
            valid_q     <= '0;
            dirty_q     <= '0;
        end else begin
            // four-phase handshake, new req only once ack is low
            if (xfer_active && !xfer_done_q && !mem_req_q && !mem_ack_i) begin
                mem_req_q <= 1'b1;
            end
            if (mem_req_q && mem_ack_i) begin
                mem_req_q   <= 1'b0;
                xfer_done_q <= 1'b1;
            end
            if (xfer_end) begin
                xfer_done_q <= 1'b0;
            end

            case (state_q)
                S_IDLE: begin
                    if (fence_i) begin
                        flush_idx_q <= '0;
                        state_q     <= S_FLUSH;
                    end else if (cpu_req_valid_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        dirty_q[req_idx] <= dirty_q[req_idx] | req_we_q;
                        state_q          <= S_IDLE;
                    end else if (valid_q[req_idx] && dirty_q[req_idx]) begin
                        state_q <= S_EVICT;
                    end else begin
                        state_q <= S_REFILL;
                    end
                end
                S_EVICT: begin
                    if (xfer_end) begin
                        valid_q[req_idx] <= 1'b0;
                        dirty_q[req_idx] <= 1'b0;
                        state_q          <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (xfer_end) begin
                        valid_q[req_idx] <= 1'b1;
                        dirty_q[req_idx] <= 1'b0;
                        state_q          <= S_DONE;
                    end
                end
                S_DONE: begin
                    dirty_q[req_idx] <= req_we_q;
                    state_q          <= S_IDLE;
                end
                S_FLUSH: begin
                    // clean lines are skipped in one cycle
                    if (!need_wb || xfer_end) begin
                        valid_q[flush_idx_q] <= 1'b0;
                        dirty_q[flush_idx_q] <= 1'b0;
                        if (flush_idx_q == '1) begin
                            state_q <= S_IDLE;
                        end else begin
                            flush_idx_q <= flush_idx_q + 1'b1;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

/* rtl/mem_stage.sv */
// Data-memory stage
// decodes the timer region, issues cache requests, generates busy and
// formats store and load data for the pipeline

`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mem_en_i,
    input  mem_pkg::mem_op_e        op_i,
    input  logic [`MEM_XLEN-1:0]    addr_i,
    input  logic [`MEM_XLEN-1:0]    wdata_i,
    input  logic                    we_i,
    input  logic                    fence_i,
    output logic [`MEM_XLEN-1:0]    rdata_o,
    output logic                    busy_o,
    output logic                    timer_irq_o,
    output logic                    mem_req_o,
    input  logic                    mem_ack_i,
    output logic [`MEM_XLEN-1:0]    mem_addr_o,
    output logic                    mem_we_o,
    output logic [`MEM_LINE_W-1:0]  mem_wdata_o,
    input  logic [`MEM_LINE_W-1:0]  mem_rdata_i
);

    logic                  is_clint;
    logic                  cacheable;
    logic                  inflight_q;
    logic                  cpu_req_valid;
    logic                  cpu_ready;
    logic                  flushing;
    logic [`MEM_XLEN-1:0]  st_data;
    logic [7:0]            st_mask;
    logic [`MEM_XLEN-1:0]  cache_rdata;
    logic [`MEM_XLEN-1:0]  clint_rdata;
    logic [`MEM_XLEN-1:0]  load_word;

    assign is_clint  = (addr_i[31:28] == `MEM_CLINT_NIBBLE);
    assign cacheable = mem_en_i && !is_clint;

    // one request per access, held off during a flush
    assign cpu_req_valid = cacheable && !inflight_q && !flushing && !fence_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_q <= 1'b0;
        end else if (cpu_ready) begin
            inflight_q <= 1'b0;
        end else if (cpu_req_valid) begin
            inflight_q <= 1'b1;
        end
    end

    assign busy_o = flushing || fence_i || (cacheable && !cpu_ready);

    store_align u_store_align (
        .op_i     (op_i),
        .offset_i (addr_i[2:0]),
        .wdata_i  (wdata_i),
        .data_o   (st_data),
        .wmask_o  (st_mask)
    );

    dcache u_dcache (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_addr_i      (addr_i),
        .cpu_we_i        (we_i),
        .cpu_wdata_i     (st_data),
        .cpu_wmask_i     (st_mask),
        .cpu_rdata_o     (cache_rdata),
        .cpu_ready_o     (cpu_ready),
        .fence_i         (fence_i),
        .flushing_o      (flushing),
        .mem_req_o       (mem_req_o),
        .mem_ack_i       (mem_ack_i),
        .mem_addr_o      (mem_addr_o),
        .mem_we_o        (mem_we_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_rdata_i     (mem_rdata_i)
    );

    // only stores into the timer region reach mtimecmp
    clint_timer u_clint_timer (
        .clk         (clk),
        .rst         (rst),
        .we_i        (mem_en_i && we_i && is_clint),
        .sel_mtime_i (addr_i[`MEM_MTIME_SEL_BIT]),
        .wdata_i     (wdata_i),
        .rdata_o     (clint_rdata),
        .timer_irq_o (timer_irq_o)
    );

    assign load_word = is_clint ? clint_rdata : cache_rdata;

    load_extract u_load_extract (
        .op_i     (op_i),
        .offset_i (addr_i[2:0]),
        .word_i   (load_word),
        .rdata_o  (rdata_o)
    );

endmodule

/* tests/mem_checker.sv */
// Result checker for the data-memory stage
// byte shadow memory, expected load values and a timer interrupt model

`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_en_i,
    input  mem_pkg::mem_op_e      op_i,
    input  logic [`MEM_XLEN-1:0]  addr_i,
    input  logic [`MEM_XLEN-1:0]  wdata_i,
    input  logic                  we_i,
    input  logic [`MEM_XLEN-1:0]  rdata_i,
    input  logic                  busy_i,
    input  logic                  timer_irq_i,
    input  logic [63:0]           cycle_i,
    input  logic                  expect_hit_i,
    input  logic [8*16-1:0]       test_name_i,
    output int                    errors_o
);

    logic [7:0]  shadow [4096];
    logic [63:0] cmp_model, prev_mtime, prev_cmp, clint_word;
    int          busy_cycles;
    int          checks;
    int          errors;

    assign errors_o = errors;

    // initial memory contents, hashed from the whole window address
    function automatic logic [7:0] fill_byte(input logic [11:0] addr);
        logic [31:0] h;
        h = {20'd0, addr} * 32'h9e37_79b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic int op_bytes(input logic [2:0] op);
        case (op[1:0])
            2'd0: return 4;
            2'd1: return 1;
            2'd2: return 2;
            default: return 8;
        endcase
    endfunction

    function automatic logic [63:0] shadow_word(input logic [11:0] a);
        logic [63:0] w;
        for (int b = 0; b < 8; b++) w[b*8 +: 8] = shadow[{a[11:3], 3'b000} + b];
        return w;
    endfunction

    // width from bits 1:0, bit 2 set means zero-extend
    function automatic logic [63:0] expected_load(input logic [2:0] op, input logic [2:0] off,
                                                  input logic [63:0] word);
        logic [63:0] v;
        int n;
        n = op_bytes(op);
        v = '0;
        for (int i = 0; i < n; i++) v[i*8 +: 8] = word[(off + i)*8 +: 8];
        if (!op[2] && v[n*8-1]) begin
            for (int i = n; i < 8; i++) v[i*8 +: 8] = 8'hff;
        end
        return v;
    endfunction

    task automatic compare_value(input string field, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %0s %0s expected %h actual %h", test_name_i, field, exp, act);
        end
    endtask

    task automatic check_line(input int line, input logic [127:0] data);
        logic [127:0] exp;
        for (int b = 0; b < 16; b++) exp[b*8 +: 8] = shadow[line*16 + b];
        checks++;
        if (data !== exp) begin
            errors++;
            $display("Error: %0s line %0d expected %h actual %h", test_name_i, line, exp, data);
        end
    endtask

    task automatic print_summary();
        $display("mem_checker: %0d checks, %0d errors", checks, errors);
    endtask

    initial begin
        for (int a = 0; a < 4096; a++) shadow[a] = fill_byte(a);
        checks = 0;
        errors = 0;
        busy_cycles = 0;
        cmp_model = '1;
    end

    always @(negedge clk) begin
        if (rst) begin
            prev_mtime  = cycle_i;
            prev_cmp    = '1;
            cmp_model   = '1;
            busy_cycles = 0;
        end else begin
            // irq registered from the previous cycle's mtime and mtimecmp
            compare_value("timer_irq_o", prev_mtime >= prev_cmp, timer_irq_i);
            prev_mtime = cycle_i;
            prev_cmp   = cmp_model;
            if (mem_en_i && busy_i) busy_cycles++;
            if (mem_en_i && !busy_i) begin
                if (addr_i[31:28] == `MEM_CLINT_NIBBLE) begin
                    clint_word = addr_i[`MEM_MTIME_SEL_BIT] ? cycle_i : cmp_model;
                    if (!we_i) begin
                        compare_value("timer load",
                                      expected_load(op_i, addr_i[2:0], clint_word), rdata_i);
                    end else if (!addr_i[`MEM_MTIME_SEL_BIT]) begin
                        cmp_model = wdata_i;
                    end
                end else begin
                    if (we_i) begin
                        for (int i = 0; i < op_bytes(op_i); i++) begin
                            shadow[addr_i[11:0] + i] = wdata_i[i*8 +: 8];
                        end
                    end else begin
                        compare_value("load", expected_load(op_i, addr_i[2:0],
                                      shadow_word(addr_i[11:0])), rdata_i);
                    end
                    if (expect_hit_i) compare_value("busy cycles", 64'd1, busy_cycles);
                end
                busy_cycles = 0;
            end
        end
    end

endmodule

/* tests/tb_mem_stage.sv */
// Testbench for the data-memory stage
// drives loads, stores, timer accesses and a fence, models the line memory

`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_stage;

    import mem_pkg::*;

    localparam int NUM_RANDOM = 400;
    localparam int NUM_TESTS  = NUM_RANDOM + 100;
    localparam logic [31:0] SEED = 32'h5266;
    localparam logic [63:0] RAM_BASE  = 64'h8000_0000;
    localparam logic [63:0] CMP_ADDR  = 64'h2000_0000;
    localparam logic [63:0] TIME_ADDR = 64'h2000_8000;

    logic clk, rst, mem_en_i, we_i, fence_i, busy_o, timer_irq_o;
    mem_op_e op_i;
    logic [63:0] addr_i, wdata_i, rdata_o, mem_addr_o;
    logic mem_req_o, mem_ack_i, mem_we_o;
    logic [127:0] mem_wdata_o, mem_rdata_i;
    logic [127:0] line_mem [256];
    logic [31:0] stim_lfsr, mem_lfsr;
    logic [63:0] cycles, gap;
    logic [8*16-1:0] test_name;
    logic expect_hit;
    int errors, idx;

    mem_stage mem_stage_i (
        .clk(clk), .rst(rst), .mem_en_i(mem_en_i), .op_i(op_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .we_i(we_i), .fence_i(fence_i), .rdata_o(rdata_o),
        .busy_o(busy_o), .timer_irq_o(timer_irq_o), .mem_req_o(mem_req_o),
        .mem_ack_i(mem_ack_i), .mem_addr_o(mem_addr_o), .mem_we_o(mem_we_o),
        .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i)
    );

    mem_checker u_checker (
        .clk(clk), .rst(rst), .mem_en_i(mem_en_i), .op_i(op_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .we_i(we_i), .rdata_i(rdata_o), .busy_i(busy_o),
        .timer_irq_i(timer_irq_o), .cycle_i(cycles), .expect_hit_i(expect_hit),
        .test_name_i(test_name), .errors_o(errors)
    );

    always #5 clk = ~clk;

    // cycles since reset release, same count as mtime
    always @(posedge clk) begin
        if (rst) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 1'b1;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    function automatic int width_of(input mem_op_e op);
        case (op[1:0])
            2'd0: return 4;
            2'd1: return 1;
            2'd2: return 2;
            default: return 8;
        endcase
    endfunction

    // line memory answering the four-phase handshake after 0 to 3 cycles
    always begin
        @(posedge clk);
        #1;
        if (!rst && mem_req_o) begin
            draw_bits(mem_lfsr, 2, gap);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            idx = mem_addr_o[11:4];
            if (mem_we_o) line_mem[idx] = mem_wdata_o;
            else mem_rdata_i = line_mem[idx];
            mem_ack_i = 1'b1;
            while (mem_req_o) begin
                @(posedge clk);
                #1;
            end
            mem_ack_i = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // holds the access until busy_o drops, then releases the bus
    task automatic access(input mem_op_e op, input logic [63:0] addr,
                          input logic [63:0] data, input logic we, input logic hit);
        op_i = op;
        addr_i = addr;
        wdata_i = data;
        we_i = we;
        expect_hit = hit;
        mem_en_i = 1'b1;
        @(negedge clk);
        while (busy_o) @(negedge clk);
        next_cycle();
        mem_en_i = 1'b0;
        expect_hit = 1'b0;
    endtask

    task automatic store_load_test();
        logic [63:0] data;
        logic [63:0] a;
        int n;
        test_name = "store_load";
        for (int w = 0; w < 4; w++) begin
            n = width_of(mem_op_e'(w));
            for (int off = 0; off < 8; off += n) begin
                draw_bits(stim_lfsr, 64, data);
                a = RAM_BASE + 64'h100 + off;
                access(mem_op_e'(w), a, data, 1'b1, 1'b0);
                access(mem_op_e'(w), a, '0, 1'b0, 1'b0);
                if (w != 3) access(mem_op_e'(w + 4), a, '0, 1'b0, 1'b0);
                // neighbouring bytes must survive
                access(OP_D, RAM_BASE + 64'h100, '0, 1'b0, 1'b0);
            end
        end
    endtask

    task automatic hit_timing_test();
        logic [63:0] data;
        test_name = "hit_timing";
        draw_bits(stim_lfsr, 64, data);
        access(OP_D, RAM_BASE + 64'h208, data, 1'b1, 1'b0);
        access(OP_W, RAM_BASE + 64'h20c, '0, 1'b0, 1'b1);
        access(OP_BU, RAM_BASE + 64'h201, '0, 1'b0, 1'b1);
    endtask

    task automatic timer_test();
        logic [63:0] target;
        test_name = "timer";
        access(OP_D, TIME_ADDR, '0, 1'b0, 1'b0);
        repeat (3) next_cycle();
        access(OP_W, TIME_ADDR + 64'h4, '0, 1'b0, 1'b0);
        target = cycles + 64'd40;
        access(OP_D, CMP_ADDR, target, 1'b1, 1'b0);
        // same low address bits in the cacheable region
        access(OP_D, RAM_BASE, 64'h5a5a_0000_1234_0000, 1'b1, 1'b0);
        access(OP_D, CMP_ADDR, '0, 1'b0, 1'b0);
        @(negedge clk);
        while (!timer_irq_o) @(negedge clk);
        repeat (3) next_cycle();
    endtask

    task automatic random_test(input int count);
        logic [63:0] r, offs, data, we;
        mem_op_e op;
        for (int i = 0; i < count; i++) begin
            draw_bits(stim_lfsr, 3, r);
            op = (r == 7) ? OP_D : mem_op_e'(r);
            draw_bits(stim_lfsr, 12, offs);
            offs = offs & ~(width_of(op) - 1);
            draw_bits(stim_lfsr, 1, we);
            draw_bits(stim_lfsr, 64, data);
            access(op, RAM_BASE + offs, data, we[0], 1'b0);
        end
    endtask

    task automatic fence_test();
        test_name = "fence";
        fence_i = 1'b1;
        next_cycle();
        fence_i = 1'b0;
        @(negedge clk);
        while (busy_o) @(negedge clk);
        for (int i = 0; i < 256; i++) u_checker.check_line(i, line_mem[i]);
        next_cycle();
    endtask

    initial begin
        repeat (NUM_TESTS * 40) @(posedge clk);
        $display("Timeout: no completion after %0d cycles, the DUT appears hung",
                 NUM_TESTS * 40);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mem_en_i = 1'b0;
        op_i = OP_D;
        addr_i = '0;
        wdata_i = '0;
        we_i = 1'b0;
        fence_i = 1'b0;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        expect_hit = 1'b0;
        test_name = "reset";
        stim_lfsr = SEED;
        mem_lfsr = SEED;
        for (int i = 0; i < 4096; i++) begin
            line_mem[i / 16][(i % 16) * 8 +: 8] = u_checker.fill_byte(i);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        store_load_test();
        hit_timing_test();
        timer_test();
        test_name = "random";
        random_test(NUM_RANDOM);
        fence_test();
        test_name = "after_fence";
        random_test(16);
        next_cycle();
        u_checker.print_summary();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/store_align.sv
rtl/load_extract.sv
rtl/clint_timer.sv
rtl/dcache.sv
rtl/mem_stage.sv
tests/mem_checker.sv
tests/tb_mem_stage.sv
